// ==== common/lq_pkg.sv ====
`default_nettype none

package lq_pkg;

    localparam int LQ_DEPTH = 16;
    localparam int COMMIT_W = 2;
    localparam int LQ_PTR_W = $clog2(LQ_DEPTH);

    typedef logic [LQ_PTR_W-1:0] lq_ptr_t;
    // position plus wrap bit in the msb
    typedef logic [LQ_PTR_W:0]   lq_idx_t;
    typedef logic [28:0]         word_addr_t;
    typedef logic [7:0]          byte_mask_t;
    typedef logic [63:0]         xlen_data_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [1:0]          commit_cnt_t;

    // position n entries further on, n below depth
    function automatic lq_ptr_t ptr_add(lq_ptr_t p, int unsigned n, int unsigned depth);
        int unsigned s;
        s = p + n;
        if (s >= depth) begin
            s = s - depth;
        end
        return lq_ptr_t'(s);
    endfunction

    // wrap bit flips when the position wraps around
    function automatic lq_idx_t idx_add(lq_idx_t idx, int unsigned n, int unsigned depth);
        lq_ptr_t pos;
        pos = ptr_add(idx[LQ_PTR_W-1:0], n, depth);
        return {idx[LQ_PTR_W] ^ (pos < idx[LQ_PTR_W-1:0]), pos};
    endfunction

    // entries behind the head get the flipped wrap bit
    function automatic lq_idx_t idx_from_pos(lq_ptr_t pos, lq_idx_t head);
        logic wrap;
        wrap = (pos >= head[LQ_PTR_W-1:0]) ? head[LQ_PTR_W] : ~head[LQ_PTR_W];
        return {wrap, pos};
    endfunction

    // distance from head in age order, out of range when idx is older than head
    function automatic int idx_age(lq_idx_t idx, lq_idx_t head, int depth);
        int pos_i;
        int pos_h;
        pos_i = int'(idx[LQ_PTR_W-1:0]);
        pos_h = int'(head[LQ_PTR_W-1:0]);
        if (idx[LQ_PTR_W] == head[LQ_PTR_W]) begin
            return pos_i - pos_h;
        end
        return pos_i + depth - pos_h;
    endfunction

endpackage

`default_nettype wire

// ==== load_queue/lq_pointers.sv ====
`timescale 1ns/100ps
`default_nettype none

module lq_pointers import lq_pkg::*; #(
    parameter int DEPTH    = LQ_DEPTH,
    parameter int COMMIT_W = lq_pkg::COMMIT_W
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        dis_en_i,
    input  commit_cnt_t commit_num_i,
    output lq_idx_t     head_o,
    output lq_idx_t     tail_o,
    output commit_cnt_t credit_ret_o
);

    lq_idx_t     head_n;
    lq_idx_t     tail_n;

    always_comb begin
        tail_n = tail_o;
        if (dis_en_i) begin
            tail_n = idx_add(tail_o, 1, DEPTH);
        end
    end

    assign head_n = idx_add(head_o, commit_num_i, DEPTH);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_o <= '0;
            tail_o <= '0;
        end else begin
            head_o <= head_n;
            tail_o <= tail_n;
        end
    end

    // freed entries go back to the dispatcher one cycle later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credit_ret_o <= '0;
        end else begin
            credit_ret_o <= commit_num_i;
        end
    end

endmodule

`default_nettype wire

// ==== load_queue/lq_entry_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module lq_entry_array import lq_pkg::*; #(
    parameter int DEPTH    = LQ_DEPTH,
    parameter int COMMIT_W = lq_pkg::COMMIT_W
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             dis_en_i,
    input  lq_idx_t          tail_i,
    input  lq_idx_t          head_i,
    input  commit_cnt_t      commit_num_i,

    input  logic             iss_en_i,
    input  lq_idx_t          iss_idx_i,
    input  word_addr_t       iss_addr_i,
    input  byte_mask_t       iss_mask_i,
    input  reg_idx_t         iss_rd_i,
    input  logic             iss_miss_i,

    input  logic             refill_en_i,
    input  lq_idx_t          refill_idx_i,
    input  xlen_data_t       refill_data_i,

    input  logic             wb_done_i,
    input  lq_idx_t          wb_done_idx_i,

    output logic [DEPTH-1:0] ready_o,
    output logic [DEPTH-1:0] issued_o,
    output reg_idx_t         rd_o [DEPTH],
    output xlen_data_t       data_o [DEPTH],
    output word_addr_t       addr_o [DEPTH],
    output byte_mask_t       mask_o [DEPTH]
);

    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] addressed;
    logic [DEPTH-1:0] miss;
    logic [DEPTH-1:0] data_valid;
    logic [DEPTH-1:0] written_back;

    lq_ptr_t tail_pos;
    lq_ptr_t head_pos;
    lq_ptr_t iss_pos;
    lq_ptr_t refill_pos;
    lq_ptr_t done_pos;

    assign tail_pos   = tail_i[LQ_PTR_W-1:0];
    assign head_pos   = head_i[LQ_PTR_W-1:0];
    assign iss_pos    = iss_idx_i[LQ_PTR_W-1:0];
    assign refill_pos = refill_idx_i[LQ_PTR_W-1:0];
    assign done_pos   = wb_done_idx_i[LQ_PTR_W-1:0];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid        <= '0;
            addressed    <= '0;
            miss         <= '0;
            data_valid   <= '0;
            written_back <= '0;
        end else begin
            // retire from the head
            for (int j = 0; j < COMMIT_W; j++) begin
                if (j < commit_num_i) begin
                    valid[ptr_add(head_pos, j, DEPTH)] <= 1'b0;
                end
            end
            if (dis_en_i) begin
                valid[tail_pos]        <= 1'b1;
                addressed[tail_pos]    <= 1'b0;
                miss[tail_pos]         <= 1'b0;
                data_valid[tail_pos]   <= 1'b0;
                written_back[tail_pos] <= 1'b0;
            end
            // a hit is already written back by the pipeline
            if (iss_en_i) begin
                addressed[iss_pos]    <= 1'b1;
                miss[iss_pos]         <= iss_miss_i;
                data_valid[iss_pos]   <= ~iss_miss_i;
                written_back[iss_pos] <= ~iss_miss_i;
            end
            if (refill_en_i) begin
                data_valid[refill_pos] <= 1'b1;
            end
            if (wb_done_i) begin
                written_back[done_pos] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss_en_i) begin
            addr_o[iss_pos] <= iss_addr_i;
            mask_o[iss_pos] <= iss_mask_i;
            rd_o[iss_pos]   <= iss_rd_i;
        end
        if (refill_en_i) begin
            data_o[refill_pos] <= refill_data_i;
        end
    end

    assign ready_o  = valid & miss & data_valid & ~written_back;
    assign issued_o = valid & addressed;

endmodule

`default_nettype wire

// ==== load_queue/lq_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module lq_writeback import lq_pkg::*; #(
    parameter int DEPTH = LQ_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [DEPTH-1:0] ready_i,
    input  reg_idx_t         rd_i [DEPTH],
    input  xlen_data_t       data_i [DEPTH],
    input  lq_idx_t          head_i,
    input  logic             wb_ready_i,
    output logic             wb_valid_o,
    output reg_idx_t         wb_rd_o,
    output xlen_data_t       wb_data_o,
    output lq_idx_t          wb_idx_o,
    output logic             wb_done_o,
    output lq_idx_t          wb_done_idx_o
);

    logic [DEPTH-1:0] cand;
    lq_ptr_t          head_pos;
    lq_ptr_t          scan_pos;
    lq_ptr_t          sel_pos;
    logic             sel_found;
    logic             load_en;

    assign head_pos = head_i[LQ_PTR_W-1:0];

    // held entry stays out until its transfer
    always_comb begin
        cand = ready_i;
        if (wb_valid_o) begin
            cand[wb_idx_o[LQ_PTR_W-1:0]] = 1'b0;
        end
    end

    // oldest first, scanning from the head
    always_comb begin
        sel_found = 1'b0;
        sel_pos   = head_pos;
        scan_pos  = head_pos;
        for (int k = 0; k < DEPTH; k++) begin
            scan_pos = ptr_add(head_pos, k, DEPTH);
            if (!sel_found && cand[scan_pos]) begin
                sel_found = 1'b1;
                sel_pos   = scan_pos;
            end
        end
    end

    assign load_en = !wb_valid_o || wb_ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_valid_o <= 1'b0;
        end else if (load_en) begin
            wb_valid_o <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && sel_found) begin
            wb_rd_o   <= rd_i[sel_pos];
            wb_data_o <= data_i[sel_pos];
            wb_idx_o  <= idx_from_pos(sel_pos, head_i);
        end
    end

    assign wb_done_o     = wb_valid_o && wb_ready_i;
    assign wb_done_idx_o = wb_idx_o;

endmodule

`default_nettype wire

// ==== load_queue/lq_violation_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module lq_violation_check import lq_pkg::*; #(
    parameter int DEPTH = LQ_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             st_en_i,
    input  lq_idx_t          st_lq_idx_i,
    input  word_addr_t       st_addr_i,
    input  byte_mask_t       st_mask_i,
    input  lq_idx_t          head_i,
    input  lq_idx_t          tail_i,
    input  logic [DEPTH-1:0] issued_i,
    input  word_addr_t       addr_i [DEPTH],
    input  byte_mask_t       mask_i [DEPTH],
    output logic             vio_valid_o,
    output lq_idx_t          vio_lq_idx_o
);

    logic [DEPTH-1:0] match;
    lq_ptr_t          head_pos;
    lq_ptr_t          scan_pos;
    lq_ptr_t          hit_pos;
    logic             hit_found;
    int               st_age;
    int               tail_age;

    assign head_pos = head_i[LQ_PTR_W-1:0];

    for (genvar i = 0; i < DEPTH; i++) begin : g_match
        assign match[i] = issued_i[i] && (addr_i[i] == st_addr_i) && |(mask_i[i] & st_mask_i);
    end

    always_comb begin
        tail_age = idx_age(tail_i, head_i, DEPTH);
        st_age   = idx_age(st_lq_idx_i, head_i, DEPTH);
        // store older than the head, every load left is younger
        if (st_age < 0 || st_age > DEPTH) begin
            st_age = 0;
        end
    end

    // first hit from the store index on is the oldest violating load
    always_comb begin
        hit_found = 1'b0;
        hit_pos   = head_pos;
        scan_pos  = head_pos;
        for (int k = 0; k < DEPTH; k++) begin
            scan_pos = ptr_add(head_pos, k, DEPTH);
            if (!hit_found && match[scan_pos] && k >= st_age && k < tail_age) begin
                hit_found = 1'b1;
                hit_pos   = scan_pos;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vio_valid_o <= 1'b0;
        end else begin
            vio_valid_o <= st_en_i && hit_found;
        end
    end

    always_ff @(posedge clk) begin
        if (st_en_i && hit_found) begin
            vio_lq_idx_o <= idx_from_pos(hit_pos, head_i);
        end
    end

endmodule

`default_nettype wire

// ==== load_queue/load_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_queue import lq_pkg::*; #(
    parameter int DEPTH    = LQ_DEPTH,
    parameter int COMMIT_W = lq_pkg::COMMIT_W
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        dis_en_i,
    output lq_idx_t     dis_lq_idx_o,
    output commit_cnt_t credit_ret_o,

    input  logic        iss_en_i,
    input  lq_idx_t     iss_idx_i,
    input  word_addr_t  iss_addr_i,
    input  byte_mask_t  iss_mask_i,
    input  reg_idx_t    iss_rd_i,
    input  logic        iss_miss_i,

    input  logic        refill_en_i,
    input  lq_idx_t     refill_idx_i,
    input  xlen_data_t  refill_data_i,

    output logic        wb_valid_o,
    input  logic        wb_ready_i,
    output reg_idx_t    wb_rd_o,
    output xlen_data_t  wb_data_o,
    output lq_idx_t     wb_idx_o,

    input  commit_cnt_t commit_num_i,

    input  logic        st_en_i,
    input  lq_idx_t     st_lq_idx_i,
    input  word_addr_t  st_addr_i,
    input  byte_mask_t  st_mask_i,

    output logic        vio_valid_o,
    output lq_idx_t     vio_lq_idx_o
);

    lq_idx_t          head;
    lq_idx_t          tail;
    logic [DEPTH-1:0] ent_ready;
    logic [DEPTH-1:0] ent_issued;
    reg_idx_t         ent_rd [DEPTH];
    xlen_data_t       ent_data [DEPTH];
    word_addr_t       ent_addr [DEPTH];
    byte_mask_t       ent_mask [DEPTH];
    logic             wb_done;
    lq_idx_t          wb_done_idx;

    assign dis_lq_idx_o = tail;

    lq_pointers #(
        .DEPTH    (DEPTH),
        .COMMIT_W (COMMIT_W)
    ) u_pointers (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_en_i),
        .commit_num_i (commit_num_i),
        .head_o       (head),
        .tail_o       (tail),
        .credit_ret_o (credit_ret_o)
    );

    lq_entry_array #(
        .DEPTH    (DEPTH),
        .COMMIT_W (COMMIT_W)
    ) u_entries (
        .clk           (clk),
        .rst           (rst),
        .dis_en_i      (dis_en_i),
        .tail_i        (tail),
        .head_i        (head),
        .commit_num_i  (commit_num_i),
        .iss_en_i      (iss_en_i),
        .iss_idx_i     (iss_idx_i),
        .iss_addr_i    (iss_addr_i),
        .iss_mask_i    (iss_mask_i),
        .iss_rd_i      (iss_rd_i),
        .iss_miss_i    (iss_miss_i),
        .refill_en_i   (refill_en_i),
        .refill_idx_i  (refill_idx_i),
        .refill_data_i (refill_data_i),
        .wb_done_i     (wb_done),
        .wb_done_idx_i (wb_done_idx),
        .ready_o       (ent_ready),
        .issued_o      (ent_issued),
        .rd_o          (ent_rd),
        .data_o        (ent_data),
        .addr_o        (ent_addr),
        .mask_o        (ent_mask)
    );

    lq_writeback #(
        .DEPTH (DEPTH)
    ) u_writeback (
        .clk           (clk),
        .rst           (rst),
        .ready_i       (ent_ready),
        .rd_i          (ent_rd),
        .data_i        (ent_data),
        .head_i        (head),
        .wb_ready_i    (wb_ready_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_idx_o      (wb_idx_o),
        .wb_done_o     (wb_done),
        .wb_done_idx_o (wb_done_idx)
    );

    lq_violation_check #(
        .DEPTH (DEPTH)
    ) u_violation (
        .clk          (clk),
        .rst          (rst),
        .st_en_i      (st_en_i),
        .st_lq_idx_i  (st_lq_idx_i),
        .st_addr_i    (st_addr_i),
        .st_mask_i    (st_mask_i),
        .head_i       (head),
        .tail_i       (tail),
        .issued_i     (ent_issued),
        .addr_i       (ent_addr),
        .mask_i       (ent_mask),
        .vio_valid_o  (vio_valid_o),
        .vio_lq_idx_o (vio_lq_idx_o)
    );

endmodule

`default_nettype wire

// ==== tb/lq_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module lq_chk import lq_pkg::*; #(
    parameter int COMMIT_W = lq_pkg::COMMIT_W
) (
    input logic        clk,
    input logic        rst,
    input logic        wb_valid_i,
    input logic        wb_ready_i,
    input reg_idx_t    wb_rd_i,
    input xlen_data_t  wb_data_i,
    input lq_idx_t     wb_idx_i,
    input commit_cnt_t credit_ret_i,
    input logic        st_en_i,
    input logic        vio_valid_i
);

    int fail_cnt = 0;

    // offered writeback waits with a steady payload
    a_wb_hold: assert property (@(posedge clk) disable iff (!rst)
        wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_rd_i)
            && $stable(wb_data_i) && $stable(wb_idx_i))
        else begin
            $error("writeback changed or dropped before it was accepted");
            fail_cnt++;
        end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst)
        credit_ret_i <= COMMIT_W)
        else begin
            $error("credit return above the commit width");
            fail_cnt++;
        end

    a_vio_after_store: assert property (@(posedge clk) disable iff (!rst)
        vio_valid_i |-> $past(st_en_i))
        else begin
            $error("violation reported without a store one cycle before");
            fail_cnt++;
        end

endmodule

bind load_queue lq_chk #(
    .COMMIT_W (COMMIT_W)
) u_chk (
    .clk          (clk),
    .rst          (rst),
    .wb_valid_i   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_rd_i      (wb_rd_o),
    .wb_data_i    (wb_data_o),
    .wb_idx_i     (wb_idx_o),
    .credit_ret_i (credit_ret_o),
    .st_en_i      (st_en_i),
    .vio_valid_i  (vio_valid_o)
);

`default_nettype wire

// ==== tb/tb_load_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_load_queue import lq_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        dis_en_i;
    lq_idx_t     dis_lq_idx_o;
    commit_cnt_t credit_ret_o;
    logic        iss_en_i;
    lq_idx_t     iss_idx_i;
    word_addr_t  iss_addr_i;
    byte_mask_t  iss_mask_i;
    reg_idx_t    iss_rd_i;
    logic        iss_miss_i;
    logic        refill_en_i;
    lq_idx_t     refill_idx_i;
    xlen_data_t  refill_data_i;
    logic        wb_valid_o;
    logic        wb_ready_i;
    reg_idx_t    wb_rd_o;
    xlen_data_t  wb_data_o;
    lq_idx_t     wb_idx_o;
    commit_cnt_t commit_num_i;
    logic        st_en_i;
    lq_idx_t     st_lq_idx_i;
    word_addr_t  st_addr_i;
    byte_mask_t  st_mask_i;
    logic        vio_valid_o;
    lq_idx_t     vio_lq_idx_o;

    int          errors = 0;
    int          test_err_base = 0;
    int          cycles = 0;
    int          credits = LQ_DEPTH;
    logic [31:0] seed;
    // model pointers, a 5-bit index wraps on its own for 16 entries
    lq_idx_t     head_m = '0;
    lq_idx_t     tail_m = '0;
    reg_idx_t    exp_rd [LQ_DEPTH];
    xlen_data_t  exp_data [LQ_DEPTH];
    lq_idx_t     got_idx [$];
    reg_idx_t    got_rd [$];
    xlen_data_t  got_data [$];
    lq_idx_t     exp_order [$];

    load_queue #(
        .DEPTH    (LQ_DEPTH),
        .COMMIT_W (COMMIT_W)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .dis_en_i      (dis_en_i),
        .dis_lq_idx_o  (dis_lq_idx_o),
        .credit_ret_o  (credit_ret_o),
        .iss_en_i      (iss_en_i),
        .iss_idx_i     (iss_idx_i),
        .iss_addr_i    (iss_addr_i),
        .iss_mask_i    (iss_mask_i),
        .iss_rd_i      (iss_rd_i),
        .iss_miss_i    (iss_miss_i),
        .refill_en_i   (refill_en_i),
        .refill_idx_i  (refill_idx_i),
        .refill_data_i (refill_data_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_idx_o      (wb_idx_o),
        .commit_num_i  (commit_num_i),
        .st_en_i       (st_en_i),
        .st_lq_idx_i   (st_lq_idx_i),
        .st_addr_i     (st_addr_i),
        .st_mask_i     (st_mask_i),
        .vio_valid_o   (vio_valid_o),
        .vio_lq_idx_o  (vio_lq_idx_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // dispatcher credits, one per allocation, returned values added back
    always @(posedge clk) begin
        if (rst) begin
            credits = credits + int'(credit_ret_o) - int'(dis_en_i);
            if (credits < 0) begin
                $display("dispatcher credits dropped below zero");
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst && wb_valid_o && wb_ready_i) begin
            got_idx.push_back(wb_idx_o);
            got_rd.push_back(wb_rd_o);
            got_data.push_back(wb_data_o);
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_idx(string name, lq_idx_t got, lq_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(string name, xlen_data_t got, xlen_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, commit_cnt_t got, commit_cnt_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        $display("%-16s %s, %0d errors", name,
                 (errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic alloc_loads(int n);
        for (int k = 0; k < n; k++) begin
            if (credits <= 0) begin
                $display("dispatcher has no credit left for allocation %0d", k);
                errors++;
            end else begin
                check_idx("dis_lq_idx_o", dis_lq_idx_o, tail_m);
                dis_en_i = 1'b1;
                next_cycle();
                tail_m = tail_m + 1'b1;
            end
        end
        dis_en_i = 1'b0;
        check_idx("dis_lq_idx_o", dis_lq_idx_o, tail_m);
    endtask

    task automatic issue_load(lq_idx_t idx, word_addr_t addr, byte_mask_t mask, logic miss);
        reg_idx_t rd;
        seed = xorshift32(seed);
        rd = reg_idx_t'(seed >> 7);
        iss_en_i   = 1'b1;
        iss_idx_i  = idx;
        iss_addr_i = addr;
        iss_mask_i = mask;
        iss_rd_i   = rd;
        iss_miss_i = miss;
        exp_rd[idx[LQ_PTR_W-1:0]] = rd;
        next_cycle();
        iss_en_i = 1'b0;
    endtask

    task automatic refill_load(lq_idx_t idx);
        xlen_data_t data;
        seed = xorshift32(seed);
        data[63:32] = seed;
        seed = xorshift32(seed);
        data[31:0] = seed;
        refill_en_i   = 1'b1;
        refill_idx_i  = idx;
        refill_data_i = data;
        exp_data[idx[LQ_PTR_W-1:0]] = data;
        next_cycle();
        refill_en_i = 1'b0;
    endtask

    // retire everything, random or full-width counts per cycle
    task automatic drain_queue(logic random_cnt);
        commit_cnt_t c;
        lq_idx_t     occ;
        occ = tail_m - head_m;
        while (occ != 0) begin
            seed = xorshift32(seed);
            c = random_cnt ? commit_cnt_t'(seed % 3) : commit_cnt_t'(COMMIT_W);
            if (c > occ) begin
                c = commit_cnt_t'(occ);
            end
            commit_num_i = c;
            next_cycle();
            head_m = head_m + c;
            check_count("credit_ret_o", credit_ret_o, c);
            occ = tail_m - head_m;
        end
        commit_num_i = '0;
        next_cycle();
        check_count("credit_ret_o", credit_ret_o, '0);
        if (credits != LQ_DEPTH) begin
            $display("dispatcher holds %0d credits on an empty queue, not %0d", credits, LQ_DEPTH);
            errors++;
        end
    endtask

    task automatic wait_transfers(int n);
        while (got_idx.size() < n) begin
            next_cycle();
        end
    endtask

    task automatic compare_transfers();
        lq_ptr_t pos;
        if (got_idx.size() != exp_order.size()) begin
            $display("%0d writebacks seen where %0d were expected",
                     got_idx.size(), exp_order.size());
            errors++;
        end else begin
            foreach (exp_order[k]) begin
                pos = exp_order[k][LQ_PTR_W-1:0];
                check_idx("wb_idx_o", got_idx[k], exp_order[k]);
                check_reg("wb_rd_o", got_rd[k], exp_rd[pos]);
                check_data("wb_data_o", got_data[k], exp_data[pos]);
            end
        end
        got_idx.delete();
        got_rd.delete();
        got_data.delete();
        exp_order.delete();
    endtask

    task automatic store_check(lq_idx_t st_idx, word_addr_t addr, byte_mask_t mask,
                               logic exp_vio, lq_idx_t exp_idx);
        st_en_i     = 1'b1;
        st_lq_idx_i = st_idx;
        st_addr_i   = addr;
        st_mask_i   = mask;
        next_cycle();
        st_en_i = 1'b0;
        check_flag("vio_valid_o", vio_valid_o, exp_vio);
        if (exp_vio) begin
            check_idx("vio_lq_idx_o", vio_lq_idx_o, exp_idx);
        end
        next_cycle();
        check_flag("vio_valid_o", vio_valid_o, 1'b0);
    endtask

    task automatic alloc_order();
        check_idx("dis_lq_idx_o", dis_lq_idx_o, '0);
        check_count("credit_ret_o", credit_ret_o, '0);
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
        check_flag("vio_valid_o", vio_valid_o, 1'b0);
        alloc_loads(LQ_DEPTH);
        // position back at 0, wrap bit set
        check_idx("dis_lq_idx_o", dis_lq_idx_o, {1'b1, lq_ptr_t'(0)});
        finish_test("alloc_order");
    endtask

    task automatic credit_return();
        drain_queue(1'b1);
        alloc_loads(LQ_DEPTH);
        if (credits != 0) begin
            $display("dispatcher holds %0d credits on a full queue", credits);
            errors++;
        end
        drain_queue(1'b1);
        finish_test("credit_return");
    endtask

    task automatic miss_writeback();
        lq_idx_t base;
        base = tail_m;
        alloc_loads(4);
        for (int k = 0; k < 4; k++) begin
            seed = xorshift32(seed);
            issue_load(lq_idx_t'(base + k), word_addr_t'(seed), 8'hff, 1'b1);
        end
        wb_ready_i = 1'b0;
        // first refill is latched alone, the other three wait together
        refill_load(lq_idx_t'(base + 2));
        refill_load(base);
        refill_load(lq_idx_t'(base + 3));
        refill_load(lq_idx_t'(base + 1));
        wb_ready_i = 1'b1;
        wait_transfers(4);
        repeat (4) next_cycle();
        exp_order.push_back(lq_idx_t'(base + 2));
        exp_order.push_back(base);
        exp_order.push_back(lq_idx_t'(base + 1));
        exp_order.push_back(lq_idx_t'(base + 3));
        compare_transfers();
        drain_queue(1'b0);
        finish_test("miss_writeback");
    endtask

    task automatic back_pressure();
        lq_idx_t base;
        lq_ptr_t pos;
        base = tail_m;
        alloc_loads(2);
        for (int k = 0; k < 2; k++) begin
            seed = xorshift32(seed);
            issue_load(lq_idx_t'(base + k), word_addr_t'(seed), 8'h0f, 1'b1);
        end
        wb_ready_i = 1'b0;
        refill_load(lq_idx_t'(base + 1));
        refill_load(base);
        while (!wb_valid_o) begin
            next_cycle();
        end
        pos = lq_ptr_t'(base + 1);
        repeat (5) begin
            check_flag("wb_valid_o", wb_valid_o, 1'b1);
            check_idx("wb_idx_o", wb_idx_o, lq_idx_t'(base + 1));
            check_reg("wb_rd_o", wb_rd_o, exp_rd[pos]);
            check_data("wb_data_o", wb_data_o, exp_data[pos]);
            next_cycle();
        end
        wb_ready_i = 1'b1;
        wait_transfers(2);
        repeat (3) next_cycle();
        exp_order.push_back(lq_idx_t'(base + 1));
        exp_order.push_back(base);
        compare_transfers();
        drain_queue(1'b0);
        finish_test("back_pressure");
    endtask

    task automatic hit_loads();
        lq_idx_t base;
        base = tail_m;
        alloc_loads(3);
        for (int k = 0; k < 3; k++) begin
            seed = xorshift32(seed);
            issue_load(lq_idx_t'(base + k), word_addr_t'(seed), 8'hff, 1'b0);
        end
        // stray refill of a hit changes nothing
        refill_load(base);
        repeat (6) next_cycle();
        check_flag("wb_valid_o", wb_valid_o, 1'b0);
        compare_transfers();
        drain_queue(1'b0);
        finish_test("hit_loads");
    endtask

    task automatic store_violation();
        lq_idx_t    base;
        word_addr_t addr;
        base = tail_m;
        seed = xorshift32(seed);
        addr = word_addr_t'(seed);
        // base + 3 keeps a matching address from an earlier use of the entry
        issue_load(lq_idx_t'(base + 3), addr, 8'h0f, 1'b0);
        alloc_loads(5);
        issue_load(base, addr, 8'h0f, 1'b0);
        issue_load(lq_idx_t'(base + 1), addr, 8'h0f, 1'b0);
        issue_load(lq_idx_t'(base + 2), addr, 8'h0f, 1'b0);
        // base + 3 stays unissued
        issue_load(lq_idx_t'(base + 4), addr, 8'hc0, 1'b0);
        store_check(lq_idx_t'(base + 1), addr, 8'h03, 1'b1, lq_idx_t'(base + 1));
        store_check(lq_idx_t'(base + 1), addr, 8'h30, 1'b0, '0);
        store_check(lq_idx_t'(base + 3), addr, 8'h0f, 1'b0, '0);
        store_check(tail_m, addr, 8'h0f, 1'b0, '0);
        drain_queue(1'b0);
        finish_test("store_violation");
    endtask

    initial begin
        rst           = 1'b0;
        dis_en_i      = 1'b0;
        iss_en_i      = 1'b0;
        iss_idx_i     = '0;
        iss_addr_i    = '0;
        iss_mask_i    = '0;
        iss_rd_i      = '0;
        iss_miss_i    = 1'b0;
        refill_en_i   = 1'b0;
        refill_idx_i  = '0;
        refill_data_i = '0;
        wb_ready_i    = 1'b0;
        commit_num_i  = '0;
        st_en_i       = 1'b0;
        st_lq_idx_i   = '0;
        st_addr_i     = '0;
        st_mask_i     = '0;
        seed          = 32'h8fb;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;

        alloc_order();
        credit_return();
        miss_writeback();
        back_pressure();
        hit_loads();
        store_violation();

        if (dut_i.u_chk.fail_cnt != 0) begin
            $display("%0d assertion failures in the bound checker", dut_i.u_chk.fail_cnt);
            errors += dut_i.u_chk.fail_cnt;
        end
        $display("6 tests run, %0d errors, %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/lq_pkg.sv
load_queue/lq_pointers.sv
load_queue/lq_entry_array.sv
load_queue/lq_writeback.sv
load_queue/lq_violation_check.sv
load_queue/load_queue.sv
tb/lq_chk.sv
tb/tb_load_queue.sv

// ==== Bender.yml ====
package:
  name: load_queue

sources:
  - files:
      - common/lq_pkg.sv
      - load_queue/lq_pointers.sv
      - load_queue/lq_entry_array.sv
      - load_queue/lq_writeback.sv
      - load_queue/lq_violation_check.sv
      - load_queue/load_queue.sv
  - target: test
    files:
      - tb/lq_chk.sv
      - tb/tb_load_queue.sv
